/* include/uba_defs.svh */
// Shared constants for the Unibus adapter interrupt block, included by the package and RTL
`ifndef UBA_DEFS_SVH
`define UBA_DEFS_SVH

////////////////////
// Status register
////////////////////

// Bridge address of the status register
`define UBA_SR_ADDR 4'h1

// PI level field positions in the register data word
`define UBA_SR_PIH_LSB 3
`define UBA_SR_PIL_LSB 0

// Read-only request summary bits
`define UBA_SR_INTHI_BIT 7
`define UBA_SR_INTLO_BIT 6

////////////////////
// Device grants
////////////////////

// One-hot grant codes, bit 3 is BR7 down to bit 0 for BR4
`define UBA_INT_NUL 4'b0000
`define UBA_INT_R7  4'b1000
`define UBA_INT_R6  4'b0100
`define UBA_INT_R5  4'b0010
`define UBA_INT_R4  4'b0001

// Unibus interrupt vector width
`define UBA_VEC_W 9

`endif

/* rtl/ubaIntrReq.sv */
// Execute stage: forms the processor PI request and grants a device on a WRU cycle
`timescale 1ns/1ns

`include "uba_defs.svh"

module ubaIntrReq
   import ubaPkg::*;
(
   input  logic      clk,
   input  logic      rst,
   input  logic      wruRead,
   input  piLevelT   busPi,
   input  statusRegT status,
   input  devMaskT   devIntr,
   output piBusT     busIntr,
   output devMaskT   devIntA
);

   // Level number to one-hot PI bit
   // Level 0 gives no bit
   function automatic piBusT levelOneHot(input piLevelT lvl);
      piBusT oneHot;
      oneHot = '0;
      for (int i = 1; i <= 7; i++)
      begin
         oneHot[i] = (lvl == piLevelT'(i));
      end
      return oneHot;
   endfunction

   ////////////////////
   // PI request
   ////////////////////

   // Group request summaries
   logic reqHi;
   logic reqLo;

   assign reqHi = devIntr[3] | devIntr[2];
   assign reqLo = devIntr[1] | devIntr[0];

   // Per group one-hot request
   piBusT intrHi;
   piBusT intrLo;

   assign intrHi = reqHi ? levelOneHot(status.piHigh) : '0;
   assign intrLo = reqLo ? levelOneHot(status.piLow) : '0;

   // Both groups share the processor bus
   assign busIntr = intrHi | intrLo;

   ////////////////////
   // WRU grant
   ////////////////////

   devMaskT grantNext;

   // High group wins when both assignments match
   always_comb
   begin
      grantNext = `UBA_INT_NUL;
      if (wruRead)
      begin
         if (busPi == status.piHigh)
         begin
            // BR7 ahead of BR6
            if (devIntr[3])
               grantNext = `UBA_INT_R7;
            else if (devIntr[2])
               grantNext = `UBA_INT_R6;
         end
         else if (busPi == status.piLow)
         begin
            // BR5 ahead of BR4
            if (devIntr[1])
               grantNext = `UBA_INT_R5;
            else if (devIntr[0])
               grantNext = `UBA_INT_R4;
         end
      end
   end

   // Grant is a single cycle pulse
   always_ff @(posedge clk)
   begin
      if (rst)
         devIntA <= `UBA_INT_NUL;
      else
         devIntA <= grantNext;
   end

endmodule

/* rtl/ubaIntrTop.sv */
// Top of the Unibus adapter interrupt block; connects the bridge and the device pins
`timescale 1ns/1ns

module ubaIntrTop
   import ubaPkg::*;
(
   input  logic         clk,
   input  logic         rst,
   // Bridge register access
   input  logic         regWrite,
   input  logic         regRead,
   input  regAddrT      regAddr,
   input  regDataT      regWriteData,
   output regDataT      regReadData,
   output logic         regReadValid,
   // Bridge PI and WRU
   input  logic         wruRead,
   input  piLevelT      busPi,
   output piBusT        busIntr,
   output wruRespT      wruResp,
   output logic         wruValid,
   // Device pins
   input  devMaskT      devIntr,
   output devMaskT      devIntA,
   input  vectorT [3:0] devVector
);

   // PI assignments from decode
   statusRegT status;

   // Decode
   ubaStatusDecode ubaStatusDecode_inst (
      .clk          (clk),
      .rst          (rst),
      .regWrite     (regWrite),
      .regRead      (regRead),
      .regAddr      (regAddr),
      .regWriteData (regWriteData),
      .devIntr      (devIntr),
      .status       (status),
      .regReadData  (regReadData),
      .regReadValid (regReadValid)
   );

   // Execute
   ubaIntrReq ubaIntrReq_inst (
      .clk     (clk),
      .rst     (rst),
      .wruRead (wruRead),
      .busPi   (busPi),
      .status  (status),
      .devIntr (devIntr),
      .busIntr (busIntr),
      .devIntA (devIntA)
   );

   // Result
   ubaVectorResult ubaVectorResult_inst (
      .clk       (clk),
      .rst       (rst),
      .wruRead   (wruRead),
      .devIntA   (devIntA),
      .devVector (devVector),
      .wruResp   (wruResp),
      .wruValid  (wruValid)
   );

endmodule

/* rtl/ubaPkg.sv */
// Types shared by the interrupt block RTL and its testbench; import with ubaPkg::*
`include "uba_defs.svh"

package ubaPkg;

   ////////////////////
   // Scalar types
   ////////////////////

   // Processor PI level, 0 means disabled
   typedef logic [2:0] piLevelT;

   // One-hot PI request to the processor
   // Bit 1 is level 1 up to bit 7 for level 7
   typedef logic [7:1] piBusT;

   // One bit per bus request level
   // Bit 3 is BR7, bit 0 is BR4
   typedef logic [3:0] devMaskT;

   // Bridge register interface
   typedef logic [3:0]  regAddrT;
   typedef logic [15:0] regDataT;

   // Unibus interrupt vector
   typedef logic [`UBA_VEC_W-1:0] vectorT;

   ////////////////////
   // Structs
   ////////////////////

   // PI assignments held in the status register
   typedef struct packed {
      piLevelT piHigh;
      piLevelT piLow;
   } statusRegT;

   // Answer to a who-are-you cycle
   typedef struct packed {
      logic   hit;
      vectorT vector;
   } wruRespT;

endpackage

/* rtl/ubaStatusDecode.sv */
// Decode stage: status register writes and reads from the bridge, holds the PI assignments
`timescale 1ns/1ns

`include "uba_defs.svh"

module ubaStatusDecode
   import ubaPkg::*;
(
   input  logic      clk,
   input  logic      rst,
   input  logic      regWrite,
   input  logic      regRead,
   input  regAddrT   regAddr,
   input  regDataT   regWriteData,
   input  devMaskT   devIntr,
   output statusRegT status,
   output regDataT   regReadData,
   output logic      regReadValid
);

   ////////////////////
   // Address decode
   ////////////////////

   // Status register select
   logic srSel;

   assign srSel = (regAddr == `UBA_SR_ADDR);

   // Request summaries per group
   logic intHi;
   logic intLo;

   // High group is BR7 and BR6
   assign intHi = devIntr[3] | devIntr[2];
   // Low group is BR5 and BR4
   assign intLo = devIntr[1] | devIntr[0];

   ////////////////////
   // Write path
   ////////////////////

   // PI fields load on a write to the status address
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         status <= '0;
      end
      else if (regWrite && srSel)
      begin
         status.piHigh <= regWriteData[`UBA_SR_PIH_LSB +: 3];
         status.piLow  <= regWriteData[`UBA_SR_PIL_LSB +: 3];
      end
   end

   ////////////////////
   // Read path
   ////////////////////

   // Register image as seen by the bridge
   regDataT srImage;

   always_comb
   begin
      srImage = '0;
      srImage[`UBA_SR_INTHI_BIT] = intHi;
      srImage[`UBA_SR_INTLO_BIT] = intLo;
      srImage[`UBA_SR_PIH_LSB +: 3] = status.piHigh;
      srImage[`UBA_SR_PIL_LSB +: 3] = status.piLow;
   end

   // Valid follows every read strobe by one cycle
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         regReadValid <= 1'b0;
      end
      else
      begin
         regReadValid <= regRead;
      end
   end

   // Read data captured with the strobe
   // Other addresses read back as zero
   always_ff @(posedge clk)
   begin
      if (regRead)
      begin
         regReadData <= srSel ? srImage : '0;
      end
   end

endmodule

/* rtl/ubaVectorResult.sv */
// Result stage: turns a device grant into the WRU response carrying that device's vector
`timescale 1ns/1ns

`include "uba_defs.svh"

module ubaVectorResult
   import ubaPkg::*;
(
   input  logic         clk,
   input  logic         rst,
   input  logic         wruRead,
   input  devMaskT      devIntA,
   input  vectorT [3:0] devVector,
   output wruRespT      wruResp,
   output logic         wruValid
);

   ////////////////////
   // Stage alignment
   ////////////////////

   // WRU strobe delayed to line up with the grant
   logic wruDly;

   always_ff @(posedge clk)
   begin
      if (rst)
         wruDly <= 1'b0;
      else
         wruDly <= wruRead;
   end

   ////////////////////
   // Vector select
   ////////////////////

   // Vector of the granted device
   // Empty grant selects zero
   vectorT grantVec;
   logic   grantHit;

   always_comb
   begin
      case (devIntA)
         `UBA_INT_R7: grantVec = devVector[3];
         `UBA_INT_R6: grantVec = devVector[2];
         `UBA_INT_R5: grantVec = devVector[1];
         `UBA_INT_R4: grantVec = devVector[0];
         default:     grantVec = '0;
      endcase
   end

   assign grantHit = (devIntA != `UBA_INT_NUL);

   ////////////////////
   // Response register
   ////////////////////

   // One response per WRU, back to back allowed
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         wruValid <= 1'b0;
         wruResp  <= '0;
      end
      else
      begin
         wruValid <= wruDly;
         // Response holds between WRU cycles
         if (wruDly)
         begin
            wruResp.hit    <= grantHit;
            wruResp.vector <= grantVec;
         end
      end
   end

endmodule

/* testbench/ubaIntrTb.sv */
// Random regression of the interrupt block against a cycle model; run as top module ubaIntrTb
`timescale 1ns/1ns

`include "uba_defs.svh"

module ubaIntrTb
   import ubaPkg::*;
();

   localparam int RESET_CYCLES = 3;
   localparam int TEST_CYCLES  = 2000;
   localparam int MARGIN       = 50;
   localparam int CYCLE_LIMIT  = RESET_CYCLES + TEST_CYCLES + MARGIN;

   // Expected read response, one cycle after the strobe
   typedef struct packed {
      logic    valid;
      regDataT data;
   } readExpT;

   // Expected WRU response, two cycles after the strobe
   typedef struct packed {
      logic    valid;
      wruRespT resp;
   } wruExpT;

   logic         clk;
   logic         rst;
   logic         regWrite;
   logic         regRead;
   regAddrT      regAddr;
   regDataT      regWriteData;
   regDataT      regReadData;
   logic         regReadValid;
   logic         wruRead;
   piLevelT      busPi;
   piBusT        busIntr;
   wruRespT      wruResp;
   logic         wruValid;
   devMaskT      devIntr;
   devMaskT      devIntA;
   vectorT [3:0] devVector;

   // Model state
   statusRegT modelStatus;
   readExpT   readQ[$];
   devMaskT   grantQ[$];
   wruExpT    wruQ[$];
   logic [15:0] lfsrState;
   int        cycleCount;

   ubaIntrTop ubaIntrTop_inst (
      .clk          (clk),
      .rst          (rst),
      .regWrite     (regWrite),
      .regRead      (regRead),
      .regAddr      (regAddr),
      .regWriteData (regWriteData),
      .regReadData  (regReadData),
      .regReadValid (regReadValid),
      .wruRead      (wruRead),
      .busPi        (busPi),
      .busIntr      (busIntr),
      .wruResp      (wruResp),
      .wruValid     (wruValid),
      .devIntr      (devIntr),
      .devIntA      (devIntA),
      .devVector    (devVector)
   );

   initial
   begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   ////////////////////
   // Random source
   ////////////////////

   // 16 bit Fibonacci LFSR, taps 16 14 13 11, one step per bit
   function automatic logic [15:0] takeBits(input int n);
      logic [15:0] val;
      logic        fb;
      val = '0;
      for (int k = 0; k < n; k++)
      begin
         fb = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
         lfsrState = {lfsrState[14:0], fb};
         val = {val[14:0], fb};
      end
      return val;
   endfunction

   ////////////////////
   // Reference model
   ////////////////////

   // One-hot PI request per group, level 0 drops out
   function automatic piBusT expectPiBus(input statusRegT st, input devMaskT req);
      piBusT r;
      r = '0;
      if ((req[3] || req[2]) && st.piHigh != 3'd0)
         r[st.piHigh] = 1'b1;
      if ((req[1] || req[0]) && st.piLow != 3'd0)
         r[st.piLow] = 1'b1;
      return r;
   endfunction

   // Highest requester in the matched group, high group first
   function automatic devMaskT expectGrant(input statusRegT st, input devMaskT req,
                                           input piLevelT pi);
      if (pi == st.piHigh)
         return req[3] ? `UBA_INT_R7 : (req[2] ? `UBA_INT_R6 : `UBA_INT_NUL);
      if (pi == st.piLow)
         return req[1] ? `UBA_INT_R5 : (req[0] ? `UBA_INT_R4 : `UBA_INT_NUL);
      return `UBA_INT_NUL;
   endfunction

   // Status image, zero off the status address
   function automatic regDataT expectRead(input regAddrT addr, input statusRegT st,
                                          input devMaskT req);
      regDataT r;
      r = '0;
      if (addr == `UBA_SR_ADDR)
      begin
         r[`UBA_SR_INTHI_BIT] = req[3] | req[2];
         r[`UBA_SR_INTLO_BIT] = req[1] | req[0];
         r[`UBA_SR_PIH_LSB +: 3] = st.piHigh;
         r[`UBA_SR_PIL_LSB +: 3] = st.piLow;
      end
      return r;
   endfunction

   // Device vector behind a grant
   function automatic vectorT vectorFor(input devMaskT g);
      if (g == `UBA_INT_R7) return devVector[3];
      if (g == `UBA_INT_R6) return devVector[2];
      if (g == `UBA_INT_R5) return devVector[1];
      if (g == `UBA_INT_R4) return devVector[0];
      return '0;
   endfunction

   ////////////////////
   // Compare tasks
   ////////////////////

   task automatic failRun();
      $display("Regression failed");
      $fatal(1, "run stopped at first error");
   endtask

   task automatic checkStatus(input string name, input regDataT expVal, input regDataT actVal);
      if (actVal !== expVal)
      begin
         $display("ERR %s expected %h actual %h", name, expVal, actVal);
         failRun();
      end
   endtask

   task automatic checkPiBus(input string name, input piBusT expVal, input piBusT actVal);
      if (actVal !== expVal)
      begin
         $display("ERR %s expected %b actual %b", name, expVal, actVal);
         failRun();
      end
   endtask

   task automatic checkGrant(input string name, input devMaskT expVal, input devMaskT actVal);
      if (actVal !== expVal)
      begin
         $display("ERR %s expected %b actual %b", name, expVal, actVal);
         failRun();
      end
   endtask

   task automatic checkWru(input string name, input wruRespT expVal, input wruRespT actVal);
      if (actVal !== expVal)
      begin
         $display("ERR %s expected %h actual %h", name, expVal, actVal);
         failRun();
      end
   endtask

   task automatic checkFlag(input string name, input logic expVal, input logic actVal);
      if (actVal !== expVal)
      begin
         $display("ERR %s expected %b actual %b", name, expVal, actVal);
         failRun();
      end
   endtask

   ////////////////////
   // Per cycle steps
   ////////////////////

   // Outputs of the last edge against the queued predictions
   task automatic checkOutputs();
      readExpT rExp;
      devMaskT gExp;
      wruExpT  wExp;
      if (readQ.size() == 0 || grantQ.size() == 0 || wruQ.size() == 0)
      begin
         $display("Model queue ran empty before a check");
         failRun();
      end
      rExp = readQ.pop_front();
      gExp = grantQ.pop_front();
      wExp = wruQ.pop_front();
      checkFlag("status read valid", rExp.valid, regReadValid);
      if (rExp.valid)
         checkStatus("status read data", rExp.data, regReadData);
      checkGrant("device grant", gExp, devIntA);
      checkFlag("wru valid", wExp.valid, wruValid);
      if (wExp.valid)
         checkWru("wru response", wExp.resp, wruResp);
      // Combinational from present requests and status
      checkPiBus("pi request", expectPiBus(modelStatus, devIntr), busIntr);
   endtask

   // New inputs for the next edge, predictions queued
   task automatic driveCycle(input bit active, input bit forceRead);
      logic    doWrite;
      logic    doRead;
      logic    doWru;
      regAddrT addr;
      regDataT wData;
      piLevelT pi;
      devMaskT req;
      devMaskT g;
      readExpT rExp;
      wruExpT  wExp;
      req = active ? devMaskT'(takeBits(4)) : devIntr;
      doWrite = active && !forceRead && (takeBits(3) == 0);
      doRead = forceRead || (active && takeBits(2) == 0);
      doWru = active && !forceRead && takeBits(1);
      // Mostly the status address, sometimes any
      addr = (forceRead || takeBits(2) != 0) ? regAddrT'(`UBA_SR_ADDR) : regAddrT'(takeBits(4));
      wData = regDataT'(takeBits(16));
      // Half the time a level already assigned
      if (takeBits(1))
         pi = takeBits(1) ? modelStatus.piHigh : modelStatus.piLow;
      else
         pi = piLevelT'(takeBits(3));
      // Predictions use the status before this write lands
      rExp.valid = doRead;
      rExp.data = doRead ? expectRead(addr, modelStatus, req) : '0;
      g = doWru ? expectGrant(modelStatus, req, pi) : `UBA_INT_NUL;
      wExp.valid = doWru;
      wExp.resp.hit = (g != `UBA_INT_NUL);
      wExp.resp.vector = vectorFor(g);
      readQ.push_back(rExp);
      grantQ.push_back(g);
      wruQ.push_back(wExp);
      if (doWrite && addr == `UBA_SR_ADDR)
      begin
         modelStatus.piHigh = wData[`UBA_SR_PIH_LSB +: 3];
         modelStatus.piLow = wData[`UBA_SR_PIL_LSB +: 3];
      end
      regWrite = doWrite;
      regRead = doRead;
      regAddr = addr;
      regWriteData = wData;
      wruRead = doWru;
      busPi = pi;
      devIntr = req;
   endtask

   // Run limit
   always @(posedge clk)
   begin
      cycleCount <= cycleCount + 1;
      if (cycleCount >= CYCLE_LIMIT)
      begin
         $display("Timeout after %0d cycles without finishing the test sequence", CYCLE_LIMIT);
         failRun();
      end
   end

   ////////////////////
   // Main sequence
   ////////////////////

   initial
   begin
      int cycleIdx;
      lfsrState = 16'd93;
      cycleCount = 0;
      rst = 1'b1;
      regWrite = 1'b0;
      regRead = 1'b0;
      regAddr = '0;
      regWriteData = '0;
      wruRead = 1'b0;
      busPi = '0;
      // All devices requesting, a cleared status keeps the PI bus quiet
      devIntr = '1;
      modelStatus = '0;
      // Vectors fixed for the whole run
      for (int d = 0; d < 4; d++)
         devVector[d] = vectorT'(takeBits(`UBA_VEC_W));
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      // Quiet outputs straight out of reset
      checkPiBus("reset pi request", '0, busIntr);
      checkGrant("reset device grant", `UBA_INT_NUL, devIntA);
      checkFlag("reset wru valid", 1'b0, wruValid);
      checkFlag("reset read valid", 1'b0, regReadValid);
      // Pipeline fill, WRU needs two idle slots
      readQ.push_back('0);
      grantQ.push_back(`UBA_INT_NUL);
      wruQ.push_back('0);
      wruQ.push_back('0);
      // Two idle cycles at the end drain the pipe
      for (cycleIdx = 0; cycleIdx < TEST_CYCLES + 2; cycleIdx++)
      begin
         if (cycleIdx > 0)
            @(negedge clk);
         checkOutputs();
         driveCycle(cycleIdx < TEST_CYCLES, cycleIdx == 0);
      end
      $display("Regression passed");
      $finish;
   end

endmodule

/* ubaIntr.f */
+incdir+include
rtl/ubaPkg.sv
rtl/ubaStatusDecode.sv
rtl/ubaIntrReq.sv
rtl/ubaVectorResult.sv
rtl/ubaIntrTop.sv
testbench/ubaIntrTb.sv
